// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_cache_top
FILELIST ?= cache.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== cache.f ====
source/cache_geom_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_ctrl.sv
source/cache_top.sv
sim/tb_mem_model.sv
sim/tb_cache_top.sv

// ==== sim/tb_cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cache_top;
    import cache_geom_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_DIRECTED = 16;
    localparam int NUM_RANDOM   = 2000;
    localparam int WORST_CYCLES = 24;   // dirty miss at latency 8 plus margin
    localparam int MEM_WORDS    = 256;

    logic               clk;
    logic               proc_reset;
    logic               proc_read;
    logic               proc_write;
    proc_addr_t         proc_addr;
    logic [WORD_W-1:0]  proc_wdata;
    logic [WORD_W-1:0]  proc_rdata;
    logic               proc_stall;
    logic               mem_read;
    logic               mem_write;
    logic [BLOCK_W-1:0] mem_addr;
    logic [LINE_W-1:0]  mem_wdata;
    logic [LINE_W-1:0]  mem_rdata;
    logic               mem_ready;
    logic [3:0]         mem_latency;

    logic [31:0]          lfsr_state;
    logic [WORD_W-1:0]    shadow [MEM_WORDS];
    logic [MEM_WORDS-1:0] written;
    logic [WORD_W-1:0]    wb_expect [MEM_WORDS];    // memory contents after each writeback
    logic [63:0]          wb_done;
    logic [7:0]           req_word;
    logic [7:0]           wb_word;
    int                   errors;
    int                   checks;
    int                   stall_cycles;             // results of the last access
    logic                 saw_read;
    logic                 saw_write;
    logic                 first_is_write;
    logic [5:0]           wb_block;

    cache_top cache_top_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    tb_mem_model mem_model_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .latency    (mem_latency),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    assign req_word = {proc_addr.mem.block[5:0], proc_addr.mem.offset};

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);     // one step per bit
        end
        return val;
    endfunction

    // memory start value from the word address with a constant mixed in
    function automatic logic [WORD_W-1:0] init_word(input logic [7:0] waddr);
        return (32'(waddr) * 32'h0101_0101) ^ 32'h5eed_0c00;
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [7:0] waddr);
        return written[waddr] ? shadow[waddr] : init_word(waddr);
    endfunction

    task automatic check_flag(input logic ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("FAIL %0t: %s", $time, what);
        end
    endtask

    // one request held until stall is seen low at a rising edge
    task automatic access(input logic wr, input logic [7:0] waddr, input logic [31:0] data);
        logic accepted;
        @(negedge clk);
        proc_read      = !wr;
        proc_write     = wr;
        proc_addr      = proc_addr_t'(30'(waddr));
        proc_wdata     = data;
        mem_latency    = 4'(take_bits(3)) + 4'd1;
        stall_cycles   = 0;
        saw_read       = 1'b0;
        saw_write      = 1'b0;
        first_is_write = 1'b0;
        accepted       = 1'b0;
        while (!accepted)
        begin
            @(posedge clk);
            if ((mem_read || mem_write) && !saw_read && !saw_write)
                first_is_write = mem_write;
            saw_read  = saw_read || mem_read;
            saw_write = saw_write || mem_write;
            if (mem_write)
                wb_block = mem_addr[5:0];
            accepted = !proc_stall;
            if (proc_stall)
                stall_cycles++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // reads checked at acceptance and writebacks at mem_ready
    always @(posedge clk)
    begin
        if (!proc_reset && !proc_stall && proc_read)
        begin
            checks++;
            assert (proc_rdata == expected_word(req_word))
            else
            begin
                errors++;
                $display("FAIL %0t: read of word %0h gave %h, expected %h", $time, req_word,
                         proc_rdata, expected_word(req_word));
            end
        end
        if (!proc_reset && !proc_stall && proc_write)
        begin
            shadow[req_word]  = proc_wdata;
            written[req_word] = 1'b1;
        end
        if (!proc_reset && mem_write && mem_ready)
        begin
            for (int k = 0; k < 4; k++)
            begin
                wb_word = {mem_addr[5:0], 2'(k)};
                checks++;
                assert (mem_wdata[k*WORD_W +: WORD_W] == expected_word(wb_word))
                else
                begin
                    errors++;
                    $display("FAIL %0t: writeback of word %0h gave %h, expected %h", $time,
                             wb_word, mem_wdata[k*WORD_W +: WORD_W], expected_word(wb_word));
                end
                wb_expect[wb_word] = expected_word(wb_word);
            end
            wb_done[mem_addr[5:0]] = 1'b1;
        end
    end

    initial
    begin
        logic       wr;
        logic [5:0] blk;
        logic [1:0] off;
        logic [7:0] waddr;
        proc_reset  = 1'b1;
        proc_read   = 1'b0;
        proc_write  = 1'b0;
        proc_addr   = '0;
        proc_wdata  = '0;
        mem_latency = 4'd1;
        lfsr_state  = 32'h50c;
        written     = '0;
        wb_done     = '0;
        wb_block    = '0;
        errors      = 0;
        checks      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        proc_reset = 1'b0;
        @(posedge clk);
        check_flag(!proc_stall && !mem_read && !mem_write, "outputs not quiet after reset");

        for (int i = 0; i < NUM_LINES; i++)
        begin
            access(1'b0, 8'(i*4), '0);      // block i with tag 0
            check_flag(stall_cycles > 0 && saw_read && !saw_write,
                       "first read to an index did not stall with a memory read only");
        end
        access(1'b0, 8'h1f, '0);            // line 7 was refilled just before
        check_flag(stall_cycles == 0, "read right after a refill stalled");

        access(1'b1, 8'h09, 32'hcafe_0001);
        check_flag(stall_cycles == 0, "write hit stalled");
        access(1'b0, 8'h09, '0);
        access(1'b0, 8'h08, '0);            // neighbours of the written word
        access(1'b0, 8'h0a, '0);
        access(1'b0, 8'h0b, '0);

        access(1'b0, 8'h28, '0);            // tag 1 over the dirty victim at index 2
        check_flag(saw_write && first_is_write && wb_block == 6'd2 && saw_read,
                   "dirty miss did not write back block 2 before the refill");
        access(1'b0, 8'h2c, '0);            // clean victim at index 3
        check_flag(saw_read && !saw_write, "clean miss raised mem_write");

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            wr    = 1'(take_bits(1));
            blk   = 6'(take_bits(6));
            off   = 2'(take_bits(2));
            waddr = {blk, off};
            access(wr, waddr, take_bits(32));
        end
        @(negedge clk);
        proc_read  = 1'b0;
        proc_write = 1'b0;
        @(posedge clk);

        for (int w = 0; w < MEM_WORDS; w++)
        begin
            if (wb_done[w/4])
            begin
                checks++;
                assert (mem_model_inst.words[w] == wb_expect[w])
                else
                begin
                    errors++;
                    $display("FAIL %0t: memory word %0h holds %h, expected %h", $time, w,
                             mem_model_inst.words[w], wb_expect[w]);
                end
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        #((NUM_DIRECTED + NUM_RANDOM) * WORST_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
    input  logic                               clk,
    input  logic                               proc_reset,
    input  logic [3:0]                         latency,     // 1 to 8 cycles
    input  logic                               mem_read,
    input  logic                               mem_write,
    input  logic [cache_geom_pkg::BLOCK_W-1:0] mem_addr,
    input  logic [cache_geom_pkg::LINE_W-1:0]  mem_wdata,
    output logic [cache_geom_pkg::LINE_W-1:0]  mem_rdata,
    output logic                               mem_ready
);
    import cache_geom_pkg::*;

    localparam int MEM_LINES = 64;

    logic [WORD_W-1:0] words [MEM_LINES*4];
    logic              busy;
    logic [3:0]        count;
    logic [5:0]        line;

    // start value of each word, spread over the whole word address
    function automatic logic [WORD_W-1:0] pattern_word(input logic [7:0] waddr);
        return (32'(waddr) * 32'h0101_0101) ^ 32'h5eed_0c00;
    endfunction

    assign line = mem_addr[5:0];    // small space, upper block bits ignored

    initial
    begin
        for (int i = 0; i < MEM_LINES*4; i++)
            words[i] = pattern_word(8'(i));
    end

    always @(posedge clk)
    begin
        if (proc_reset)
        begin
            busy      <= 1'b0;
            count     <= 4'd0;
            mem_ready <= 1'b0;
            mem_rdata <= '0;
        end
        else if (mem_ready)
        begin
            mem_ready <= 1'b0;      // strobe drops at this same edge
        end
        else if (busy)
        begin
            if (count <= 4'd1)
            begin
                busy      <= 1'b0;
                mem_ready <= 1'b1;
                for (int k = 0; k < 4; k++)
                begin
                    if (mem_write)
                        words[{line, 2'(k)}] <= mem_wdata[k*WORD_W +: WORD_W];
                    mem_rdata[k*WORD_W +: WORD_W] <= words[{line, 2'(k)}];
                end
            end
            else
            begin
                count <= count - 4'd1;
            end
        end
        else if (mem_read || mem_write)
        begin
            busy  <= 1'b1;          // new transfer, latency taken now
            count <= latency;
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
    input  logic                             clk,
    input  logic                             proc_reset,
    input  logic                             proc_read,
    input  logic                             proc_write,
    input  cache_geom_pkg::proc_addr_t       addr,
    input  logic                             hit,
    input  logic                             dirty,
    input  logic [cache_geom_pkg::TAG_W-1:0] victim_tag,
    input  logic                             mem_ready,
    output logic                             proc_stall,
    output logic                             mem_read,
    output logic                             mem_write,
    output cache_ctrl_pkg::mem_addr_t        mem_addr,
    output logic                             fill,
    output logic                             set_dirty,
    output logic                             word_we,
    output logic                             clean
);
    import cache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        request;
    logic        idle_miss;

    assign request   = proc_read || proc_write;
    assign idle_miss = (state == IDLE) && request && !hit;

    always_ff @(posedge clk)
    begin
        if (proc_reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        proc_stall = 1'b1;              // held outside IDLE
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = addr.mem.block;    // block of the requested line
        fill       = 1'b0;
        set_dirty  = 1'b0;
        word_we    = 1'b0;
        clean      = 1'b0;

        case (state)
            IDLE:
            begin
                proc_stall = idle_miss;
                if (request && hit)
                begin
                    // word and dirty bit of a write hit land at this edge
                    set_dirty = proc_write;
                    word_we   = proc_write;
                end
                else if (request)
                begin
                    if (dirty)
                        state_next = WRITEBACK;   // victim must go out first
                    else
                        state_next = REFILL;
                end
            end

            WRITEBACK:
            begin
                mem_write = 1'b1;
                mem_addr  = {victim_tag, addr.lookup.index}; // old block
                if (mem_ready)
                begin
                    clean      = 1'b1;
                    state_next = REFILL;
                end
            end

            REFILL:
            begin
                mem_read = 1'b1;
                if (mem_ready)
                begin
                    fill       = 1'b1;  // line, tag and valid together
                    state_next = IDLE;  // held request hits next cycle
                end
            end

            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    // request and address stay put until memory answers
    assert property (@(posedge clk) disable iff (proc_reset)
        ((mem_read || mem_write) && !mem_ready)
            |=> $stable({mem_read, mem_write, mem_addr}))
        else $error("ctrl: memory request changed before mem_ready");

    // refilled line must serve the held request
    assert property (@(posedge clk) disable iff (proc_reset)
        fill |=> hit)
        else $error("ctrl: no hit after refill");

    assert property (@(posedge clk) disable iff (proc_reset)
        clean |=> !dirty)
        else $error("ctrl: victim still dirty after writeback");

endmodule

`default_nettype wire

// ==== source/cache_ctrl_pkg.sv ====
`default_nettype none

package cache_ctrl_pkg;

    // miss handling states
    typedef enum logic [1:0] {
        IDLE      = 2'd0,   // lookup, hits served here
        WRITEBACK = 2'd1,   // dirty victim going out
        REFILL    = 2'd2    // new line coming in
    } ctrl_state_t;

    // memory side is one line per transfer
    localparam int MEM_ADDR_W = cache_geom_pkg::BLOCK_W;
    localparam int MEM_DATA_W = cache_geom_pkg::LINE_W;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

// ==== source/cache_data_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_data_store (
    input  logic                              clk,
    input  cache_geom_pkg::proc_addr_t        addr,
    input  logic                              word_we,
    input  logic [cache_geom_pkg::WORD_W-1:0] wdata,
    input  logic                              fill,
    input  logic [cache_geom_pkg::LINE_W-1:0] fill_data,
    output logic [cache_geom_pkg::WORD_W-1:0] rdata,
    output logic [cache_geom_pkg::LINE_W-1:0] line_rdata
);
    import cache_geom_pkg::*;

    // word 0 sits in the low bits of a line
    logic [LINE_W-1:0]   lines [NUM_LINES];
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;

    assign index  = addr.lookup.index;
    assign offset = addr.lookup.offset;

    // whole line out for writebacks
    assign line_rdata = lines[index];

    // word select for processor reads
    always_comb
    begin
        rdata = line_rdata[WORD_W-1:0];
        for (int w = 1; w < (1 << OFFSET_W); w++)
        begin
            if (offset == w[OFFSET_W-1:0])
                rdata = line_rdata[w*WORD_W +: WORD_W];
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            lines[index] <= fill_data;  // refill from memory
        end
        else if (word_we)
        begin
            for (int w = 0; w < (1 << OFFSET_W); w++)
            begin
                if (offset == w[OFFSET_W-1:0])
                    lines[index][w*WORD_W +: WORD_W] <= wdata;
            end
        end
    end

    // write hits only happen in IDLE, fills only in REFILL
    assert property (@(posedge clk) !(word_we && fill))
        else $error("data store: word write during line fill");

endmodule

`default_nettype wire

// ==== source/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    localparam int WORD_W    = 32;
    localparam int OFFSET_W  = 2;                   // word in line
    localparam int INDEX_W   = 3;                   // line select
    localparam int TAG_W     = 25;
    localparam int BLOCK_W   = TAG_W + INDEX_W;     // memory line address
    localparam int LINE_W    = WORD_W << OFFSET_W;  // four words
    localparam int NUM_LINES = 1 << INDEX_W;

    // lookup view of a word address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } lookup_view_t;

    // memory view, block number plus word offset
    typedef struct packed {
        logic [BLOCK_W-1:0]  block;
        logic [OFFSET_W-1:0] offset;
    } mem_view_t;

    // one 30-bit processor word address, decoded two ways
    typedef union packed {
        lookup_view_t lookup;
        mem_view_t    mem;
    } proc_addr_t;

endpackage

`default_nettype wire

// ==== source/cache_tag_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_tag_store (
    input  logic                             clk,
    input  logic                             proc_reset,
    input  cache_geom_pkg::proc_addr_t       addr,
    input  logic                             fill,
    input  logic                             set_dirty,
    input  logic                             clean,
    output logic                             hit,
    output logic                             dirty,
    output logic [cache_geom_pkg::TAG_W-1:0] victim_tag
);
    import cache_geom_pkg::*;

    logic [NUM_LINES-1:0] valid_bits;
    logic [NUM_LINES-1:0] dirty_bits;
    logic [TAG_W-1:0]     tags [NUM_LINES];
    logic [INDEX_W-1:0]   index;

    assign index = addr.lookup.index;

    // everything below looks at the indexed line only
    assign victim_tag = tags[index];
    assign hit        = valid_bits[index] && (tags[index] == addr.lookup.tag);
    assign dirty      = valid_bits[index] && dirty_bits[index];

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid_bits <= '0;   // all lines invalid
            dirty_bits <= '0;   // and clean
        end
        else
        begin
            if (fill)
            begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= 1'b0;  // fresh copy of memory
            end
            else if (set_dirty)
            begin
                dirty_bits[index] <= 1'b1;
            end
            else if (clean)
            begin
                dirty_bits[index] <= 1'b0;  // writeback done
            end
        end
    end

    // tag written together with the refilled line
    always_ff @(posedge clk)
    begin
        if (fill)
            tags[index] <= addr.lookup.tag;
    end

    // a refill never lands in the same cycle as a write hit
    assert property (@(posedge clk) disable iff (proc_reset)
        !(fill && set_dirty))
        else $error("tag store: fill and set_dirty together");

endmodule

`default_nettype wire

// ==== source/cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_top (
    input  logic                                  clk,
    input  logic                                  proc_reset,
    // processor side
    input  logic                                  proc_read,
    input  logic                                  proc_write,
    input  cache_geom_pkg::proc_addr_t            proc_addr,
    input  logic [cache_geom_pkg::WORD_W-1:0]     proc_wdata,
    output logic [cache_geom_pkg::WORD_W-1:0]     proc_rdata,
    output logic                                  proc_stall,
    // memory side
    output logic                                  mem_read,
    output logic                                  mem_write,
    output cache_ctrl_pkg::mem_addr_t             mem_addr,
    output logic [cache_ctrl_pkg::MEM_DATA_W-1:0] mem_wdata,
    input  logic [cache_ctrl_pkg::MEM_DATA_W-1:0] mem_rdata,
    input  logic                                  mem_ready
);
    import cache_geom_pkg::*;

    logic             hit;
    logic             dirty;
    logic [TAG_W-1:0] victim_tag;
    logic             fill;
    logic             set_dirty;
    logic             word_we;
    logic             clean;

    cache_tag_store tag_store_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .addr       (proc_addr),
        .fill       (fill),
        .set_dirty  (set_dirty),
        .clean      (clean),
        .hit        (hit),
        .dirty      (dirty),
        .victim_tag (victim_tag)
    );

    // writeback data comes straight from the indexed line
    cache_data_store data_store_inst (
        .clk        (clk),
        .addr       (proc_addr),
        .word_we    (word_we),
        .wdata      (proc_wdata),
        .fill       (fill),
        .fill_data  (mem_rdata),
        .rdata      (proc_rdata),
        .line_rdata (mem_wdata)
    );

    cache_ctrl ctrl_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .addr       (proc_addr),
        .hit        (hit),
        .dirty      (dirty),
        .victim_tag (victim_tag),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .fill       (fill),
        .set_dirty  (set_dirty),
        .word_we    (word_we),
        .clean      (clean)
    );

endmodule

`default_nettype wire
